/* source/armPkg.sv */
`default_nettype none

package armPkg;

  localparam int dataWidth    = 32;  // Data word and PC width
  localparam int regAddrWidth = 4;   // Register number width
  localparam int regCount     = 16;  // Architectural registers R0..R15

  typedef logic [dataWidth-1:0]    word_t;
  typedef logic [regAddrWidth-1:0] regAddr_t;

  // R15 reads back as PC+8, as on ARM
  localparam regAddr_t pcRegNum = regAddr_t'(15);

  // ALU operations driven by the controller
  typedef enum logic [1:0] {
    aluAdd = 2'd0,
    aluSub = 2'd1,
    aluAnd = 2'd2,
    aluOrr = 2'd3
  } aluOp_t;

  // Immediate forms picked by the decoder
  typedef enum logic [1:0] {
    immByte   = 2'd0,  // Bits 7:0, zero extended
    immWord12 = 2'd1,  // Bits 11:0, zero extended
    immBranch = 2'd2   // Bits 23:0, sign extended, times 4
  } immSrc_t;

  // Bypass sources for the execute operands
  typedef enum logic [1:0] {
    fwdNone      = 2'd0,  // Register file value
    fwdWriteback = 2'd1,  // ResultW
    fwdMemory    = 2'd2   // AluOutM
  } forwardSel_t;

  typedef struct packed {
    logic n;  // Negative
    logic z;  // Zero
    logic c;  // Carry out, inverse borrow on subtract
    logic v;  // Signed overflow
  } aluFlags_t;

  localparam word_t nopInstr = '0;           // Flushed decode slot
  localparam word_t pcStep   = word_t'(4);   // One instruction

endpackage

`default_nettype wire

/* source/fetchStage.sv */
`default_nettype none

module fetchStage import armPkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  stallF,        // Hold the PC
  input  logic  branchTakenE,  // Redirect from execute
  input  word_t branchTarget,  // Execute ALU result
  output word_t pcF,
  output word_t pcPlus4F
);

  word_t pcNextF;  // Candidate for the next PC

  assign pcPlus4F = pcF + pcStep;

  // Taken branch beats sequential fetch
  always_comb begin
    if (branchTakenE) begin
      pcNextF = branchTarget;
    end else begin
      pcNextF = pcPlus4F;
    end
  end

  // A branch still loads while fetch is stalled
  always_ff @(posedge clk) begin
    if (rst) begin
      pcF <= '0;
    end else if (branchTakenE || !stallF) begin
      pcF <= pcNextF;
    end
  end

endmodule

`default_nettype wire

/* source/decodeStage.sv */
`default_nettype none

module decodeStage import armPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     stallD,    // Keep the current instruction
  input  logic     flushD,    // Replace it with a NOP
  input  word_t    instrF,
  input  word_t    pcPlus4F,
  input  logic     [1:0] regSrcD,
  input  immSrc_t  immSrcD,
  input  word_t    rd1D,      // Register file read data
  input  word_t    rd2D,
  output regAddr_t ra1D,      // Register file read addresses
  output regAddr_t ra2D,
  output word_t    pcPlus8D,  // Feeds R15 reads
  output word_t    rd1E,
  output word_t    rd2E,
  output word_t    extImmE,
  output regAddr_t ra1E,
  output regAddr_t ra2E,
  output regAddr_t waE
);

  word_t instrD;
  word_t pcPlus4D;
  word_t extImmD;

  // Fetch to decode register
  always_ff @(posedge clk) begin
    if (rst) begin
      instrD   <= nopInstr;
      pcPlus4D <= '0;
    end else if (flushD) begin
      instrD   <= nopInstr;  // Bubble after a taken branch
      pcPlus4D <= '0;
    end else if (!stallD) begin
      instrD   <= instrF;
      pcPlus4D <= pcPlus4F;
    end
  end

  assign pcPlus8D = pcPlus4D + pcStep;

  // Rn, or R15 for PC relative forms
  assign ra1D = regSrcD[0] ? pcRegNum : instrD[19:16];
  // Rd for stores, Rm otherwise
  assign ra2D = regSrcD[1] ? instrD[15:12] : instrD[3:0];

  always_comb begin
    case (immSrcD)
      immByte:   extImmD = {24'd0, instrD[7:0]};
      immWord12: extImmD = {20'd0, instrD[11:0]};
      immBranch: extImmD = {{6{instrD[23]}}, instrD[23:0], 2'b00};  // Word offset
      default:   extImmD = '0;
    endcase
  end

  // Decode to execute registers, these never stall
  always_ff @(posedge clk) begin
    if (rst) begin
      rd1E    <= '0;
      rd2E    <= '0;
      extImmE <= '0;
      ra1E    <= '0;
      ra2E    <= '0;
      waE     <= '0;
    end else begin
      rd1E    <= rd1D;
      rd2E    <= rd2D;
      extImmE <= extImmD;
      ra1E    <= ra1D;
      ra2E    <= ra2D;
      waE     <= instrD[15:12];  // Destination Rd
    end
  end

endmodule

`default_nettype wire

/* source/registerFile.sv */
`default_nettype none

module registerFile import armPkg::*; (
  input  logic     clk,
  input  logic     we,       // Writeback enable
  input  regAddr_t ra1,
  input  regAddr_t ra2,
  input  regAddr_t wa,
  input  word_t    wd,       // ResultW
  input  word_t    pcPlus8,  // Value seen for R15
  output word_t    rd1,
  output word_t    rd2,
  output word_t    r0,       // Observation of R0
  output word_t    r1        // Observation of R1
);

  word_t regs [regCount];

  // One read port, R15 first, then bypass of the write in flight
  function automatic word_t readPort(regAddr_t ra);
    word_t val;
    if (ra == pcRegNum) begin
      val = pcPlus8;
    end else if (we && (ra == wa)) begin
      val = wd;  // Write-through
    end else begin
      val = regs[ra];
    end
    return val;
  endfunction

  always_ff @(posedge clk) begin
    if (we) begin
      regs[wa] <= wd;
    end
  end

  assign rd1 = readPort(ra1);
  assign rd2 = readPort(ra2);

  assign r0 = regs[0];
  assign r1 = regs[1];

endmodule

`default_nettype wire

/* source/executeStage.sv */
`default_nettype none

module executeStage import armPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  word_t       rd1E,
  input  word_t       rd2E,
  input  word_t       extImmE,
  input  word_t       resultW,      // Writeback bypass
  input  forwardSel_t forwardAE,
  input  forwardSel_t forwardBE,
  input  logic        aluSrcE,      // High selects the immediate
  input  aluOp_t      aluControlE,
  input  regAddr_t    waE,
  output word_t       aluResultE,   // Also the branch target
  output aluFlags_t   aluFlagsE,
  output word_t       aluOutM,
  output word_t       writeDataM,
  output regAddr_t    waM
);

  word_t srcAE;
  word_t srcBE;
  word_t writeDataE;  // Forwarded Rm or Rd
  word_t bInv;        // B, inverted for subtract
  logic  isSub;
  logic  carryOut;
  word_t sum;

  always_comb begin
    case (forwardAE)
      fwdWriteback: srcAE = resultW;
      fwdMemory:    srcAE = aluOutM;
      default:      srcAE = rd1E;
    endcase
  end

  // Store data shares the B bypass
  always_comb begin
    case (forwardBE)
      fwdWriteback: writeDataE = resultW;
      fwdMemory:    writeDataE = aluOutM;
      default:      writeDataE = rd2E;
    endcase
  end

  assign srcBE = aluSrcE ? extImmE : writeDataE;

  // Subtract as A + ~B + 1, so carry is the inverse borrow
  assign isSub = (aluControlE == aluSub);
  assign bInv  = isSub ? ~srcBE : srcBE;
  assign {carryOut, sum} = {1'b0, srcAE} + {1'b0, bInv} + {{dataWidth{1'b0}}, isSub};

  always_comb begin
    aluFlagsE.c = 1'b0;  // Logic ops leave C and V clear
    aluFlagsE.v = 1'b0;
    case (aluControlE)
      aluAnd: aluResultE = srcAE & srcBE;
      aluOrr: aluResultE = srcAE | srcBE;
      default: begin
        aluResultE  = sum;
        aluFlagsE.c = carryOut;
        // Same sign in, different sign out
        aluFlagsE.v = (srcAE[dataWidth-1] == bInv[dataWidth-1]) &&
                      (sum[dataWidth-1] != srcAE[dataWidth-1]);
      end
    endcase
    aluFlagsE.n = aluResultE[dataWidth-1];
    aluFlagsE.z = (aluResultE == '0);
  end

  // Execute to memory registers
  always_ff @(posedge clk) begin
    if (rst) begin
      aluOutM    <= '0;
      writeDataM <= '0;
      waM        <= '0;
    end else begin
      aluOutM    <= aluResultE;
      writeDataM <= writeDataE;  // Store data to data memory
      waM        <= waE;
    end
  end

endmodule

`default_nettype wire

/* source/memWritebackStage.sv */
`default_nettype none

module memWritebackStage import armPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  word_t    aluOutM,
  input  word_t    readDataM,  // From the external data memory
  input  regAddr_t waM,
  input  logic     memtoRegW,  // High for loads
  output word_t    resultW,    // To the register file and bypass
  output regAddr_t waW
);

  word_t aluOutW;
  word_t readDataW;

  // Memory to writeback registers
  always_ff @(posedge clk) begin
    if (rst) begin
      aluOutW   <= '0;
      readDataW <= '0;
      waW       <= '0;
    end else begin
      aluOutW   <= aluOutM;
      readDataW <= readDataM;
      waW       <= waM;
    end
  end

  // Load data or ALU result
  always_comb begin
    if (memtoRegW) begin
      resultW = readDataW;
    end else begin
      resultW = aluOutW;
    end
  end

endmodule

`default_nettype wire

/* source/hazardMatch.sv */
`default_nettype none

module hazardMatch import armPkg::*; (
  input  regAddr_t ra1D,
  input  regAddr_t ra2D,
  input  regAddr_t ra1E,
  input  regAddr_t ra2E,
  input  regAddr_t waE,
  input  regAddr_t waM,
  input  regAddr_t waW,
  output logic     match1EM,   // Source A in E against dest in M
  output logic     match1EW,   // Source A in E against dest in W
  output logic     match2EM,   // Source B in E against dest in M
  output logic     match2EW,   // Source B in E against dest in W
  output logic     match12DE   // Either D source against dest in E
);

  logic match1DE;
  logic match2DE;

  // Forwarding candidates
  assign match1EM = (ra1E == waM);
  assign match1EW = (ra1E == waW);
  assign match2EM = (ra2E == waM);
  assign match2EW = (ra2E == waW);

  // Load-use check, a load in E feeding decode
  assign match1DE  = (ra1D == waE);
  assign match2DE  = (ra2D == waE);
  assign match12DE = match1DE | match2DE;

endmodule

`default_nettype wire

/* source/armDatapath.sv */
`default_nettype none

module armDatapath import armPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  word_t       instrF,        // From instruction memory
  input  word_t       readDataM,     // From data memory
  input  logic        stallF,
  input  logic        stallD,
  input  logic        flushD,
  input  logic        branchTakenE,
  input  logic        [1:0] regSrcD,
  input  immSrc_t     immSrcD,
  input  logic        aluSrcE,
  input  aluOp_t      aluControlE,
  input  forwardSel_t forwardAE,
  input  forwardSel_t forwardBE,
  input  logic        memtoRegW,
  input  logic        regWriteW,
  output word_t       pcF,
  output word_t       aluOutM,       // Data memory address
  output word_t       writeDataM,    // Data memory store data
  output aluFlags_t   aluFlagsE,
  output logic        match1EM,
  output logic        match1EW,
  output logic        match2EM,
  output logic        match2EW,
  output logic        match12DE,
  output word_t       r0,
  output word_t       r1
);

  word_t    pcPlus4F;
  word_t    pcPlus8D;
  word_t    rd1D;
  word_t    rd2D;
  word_t    rd1E;
  word_t    rd2E;
  word_t    extImmE;
  word_t    aluResultE;  // Branch target too
  word_t    resultW;
  regAddr_t ra1D;
  regAddr_t ra2D;
  regAddr_t ra1E;
  regAddr_t ra2E;
  regAddr_t waE;
  regAddr_t waM;
  regAddr_t waW;

  fetchStage fetchStage_i (
    .clk          (clk),
    .rst          (rst),
    .stallF       (stallF),
    .branchTakenE (branchTakenE),
    .branchTarget (aluResultE),
    .pcF          (pcF),
    .pcPlus4F     (pcPlus4F)
  );

  decodeStage decodeStage_i (
    .clk      (clk),
    .rst      (rst),
    .stallD   (stallD),
    .flushD   (flushD),
    .instrF   (instrF),
    .pcPlus4F (pcPlus4F),
    .regSrcD  (regSrcD),
    .immSrcD  (immSrcD),
    .rd1D     (rd1D),
    .rd2D     (rd2D),
    .ra1D     (ra1D),
    .ra2D     (ra2D),
    .pcPlus8D (pcPlus8D),
    .rd1E     (rd1E),
    .rd2E     (rd2E),
    .extImmE  (extImmE),
    .ra1E     (ra1E),
    .ra2E     (ra2E),
    .waE      (waE)
  );

  // Written from writeback, read in decode
  registerFile registerFile_i (
    .clk     (clk),
    .we      (regWriteW),
    .ra1     (ra1D),
    .ra2     (ra2D),
    .wa      (waW),
    .wd      (resultW),
    .pcPlus8 (pcPlus8D),
    .rd1     (rd1D),
    .rd2     (rd2D),
    .r0      (r0),
    .r1      (r1)
  );

  executeStage executeStage_i (
    .clk         (clk),
    .rst         (rst),
    .rd1E        (rd1E),
    .rd2E        (rd2E),
    .extImmE     (extImmE),
    .resultW     (resultW),
    .forwardAE   (forwardAE),
    .forwardBE   (forwardBE),
    .aluSrcE     (aluSrcE),
    .aluControlE (aluControlE),
    .waE         (waE),
    .aluResultE  (aluResultE),
    .aluFlagsE   (aluFlagsE),
    .aluOutM     (aluOutM),
    .writeDataM  (writeDataM),
    .waM         (waM)
  );

  memWritebackStage memWritebackStage_i (
    .clk       (clk),
    .rst       (rst),
    .aluOutM   (aluOutM),
    .readDataM (readDataM),
    .waM       (waM),
    .memtoRegW (memtoRegW),
    .resultW   (resultW),
    .waW       (waW)
  );

  // Raw compares for the external hazard unit
  hazardMatch hazardMatch_i (
    .ra1D      (ra1D),
    .ra2D      (ra2D),
    .ra1E      (ra1E),
    .ra2E      (ra2E),
    .waE       (waE),
    .waM       (waM),
    .waW       (waW),
    .match1EM  (match1EM),
    .match1EW  (match1EW),
    .match2EM  (match2EM),
    .match2EW  (match2EW),
    .match12DE (match12DE)
  );

endmodule

`default_nettype wire

/* tests/armDatapathTb.sv */
`default_nettype none

module armDatapathTb import armPkg::*; ();

  logic        clk;
  logic        rst;
  word_t       instrF;
  word_t       readDataM;
  logic        stallF;
  logic        stallD;
  logic        flushD;
  logic        branchTakenE;
  logic [1:0]  regSrcD;
  immSrc_t     immSrcD;
  logic        aluSrcE;
  aluOp_t      aluControlE;
  forwardSel_t forwardAE;
  forwardSel_t forwardBE;
  logic        memtoRegW;
  logic        regWriteW;
  word_t       pcF;
  word_t       aluOutM;
  word_t       writeDataM;
  aluFlags_t   aluFlagsE;
  logic        match1EM;
  logic        match1EW;
  logic        match2EM;
  logic        match2EW;
  logic        match12DE;
  word_t       r0;
  word_t       r1;

  word_t       refRegs [regCount];  // Reference register model
  int unsigned cycleCount;
  localparam int unsigned cycleLimit = 400;  // About twice the summed test lengths

  armDatapath armDatapath_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

  task automatic checkWord(input string name, input word_t exp, input word_t act);
    assert (act === exp) else begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic stepCycle();
    @(posedge clk);
    @(negedge clk);
  endtask

  // Quiet pipeline controls, NOP on the fetch bus
  task automatic setIdle();
    instrF       = nopInstr;
    readDataM    = '0;
    stallF       = 1'b0;
    stallD       = 1'b0;
    flushD       = 1'b0;
    branchTakenE = 1'b0;
    regSrcD      = 2'b00;
    immSrcD      = immByte;
    aluSrcE      = 1'b1;
    aluControlE  = aluAdd;
    forwardAE    = fwdNone;
    forwardBE    = fwdNone;
    memtoRegW    = 1'b0;
    regWriteW    = 1'b0;
  endtask

  function automatic word_t encode(input regAddr_t rn, input regAddr_t rd, input logic [11:0] low);
    return {12'd0, rn, rd, low};
  endfunction

  // Model read port, R15 gives the fetch PC plus 8
  function automatic word_t readRef(input regAddr_t ra, input word_t pc);
    if (ra == pcRegNum) begin
      return pc + 32'd8;
    end
    return refRegs[ra];
  endfunction

  function automatic word_t extendImm(input word_t instr, input immSrc_t src);
    case (src)
      immByte:   return word_t'(instr[7:0]);
      immWord12: return word_t'(instr[11:0]);
      immBranch: return word_t'($signed(instr[23:0])) << 2;
      default:   return '0;
    endcase
  endfunction

  // Expected ALU result and NZCV
  task automatic aluModel(input aluOp_t op, input word_t a, input word_t b,
                          output word_t res, output logic [3:0] nzcv);
    logic [dataWidth:0] wide;
    logic c;
    logic v;
    c = 1'b0;
    v = 1'b0;
    case (op)
      aluAdd: begin
        wide = {1'b0, a} + {1'b0, b};
        res  = wide[dataWidth-1:0];
        c    = wide[dataWidth];
        v    = (a[31] == b[31]) && (res[31] != a[31]);
      end
      aluSub: begin
        res = a - b;
        c   = (a >= b);  // No borrow
        v   = (a[31] != b[31]) && (res[31] != a[31]);
      end
      aluAnd:  res = a & b;
      default: res = a | b;
    endcase
    nzcv = {res[31], res == '0, c, v};
  endtask

  // One instruction through all five stages, nothing else in flight
  task automatic runInstr(input word_t instr, input logic [1:0] regSrc, input immSrc_t immSrc,
                          input logic aluSrc, input aluOp_t op, input logic memtoReg,
                          input logic regWrite, input word_t loadData, input bit checkExec);
    regAddr_t   rn;
    regAddr_t   ra2;
    regAddr_t   rd;
    word_t      pcFetch;
    word_t      a;
    word_t      b;
    word_t      res;
    logic [3:0] nzcv;
    pcFetch = pcF;  // PC of this instruction
    rn  = regSrc[0] ? pcRegNum : instr[19:16];
    ra2 = regSrc[1] ? instr[15:12] : instr[3:0];
    rd  = instr[15:12];
    a   = readRef(rn, pcFetch);
    b   = aluSrc ? extendImm(instr, immSrc) : readRef(ra2, pcFetch);
    aluModel(op, a, b, res, nzcv);
    instrF = instr;
    stepCycle();
    setIdle();  // Decode
    regSrcD = regSrc;
    immSrcD = immSrc;
    stepCycle();
    setIdle();  // Execute
    aluSrcE     = aluSrc;
    aluControlE = op;
    #1;  // Flags follow the new execute controls
    if (checkExec) checkWord("aluFlagsE", {28'd0, nzcv}, {28'd0, aluFlagsE});
    stepCycle();
    setIdle();  // Memory
    readDataM = loadData;
    if (checkExec) begin
      checkWord("aluOutM", res, aluOutM);
      checkWord("writeDataM", readRef(ra2, pcFetch), writeDataM);
    end
    stepCycle();
    setIdle();  // Writeback
    memtoRegW = memtoReg;
    regWriteW = regWrite;
    stepCycle();
    setIdle();
    if (regWrite) refRegs[rd] = memtoReg ? loadData : res;
    if (rd == 0) checkWord("r0", refRegs[0], r0);
    if (rd == 1) checkWord("r1", refRegs[1], r1);
  endtask

  task automatic testFetch();
    word_t pcB;
    word_t branch;
    checkWord("pcF", 32'd0, pcF);  // Right after reset
    stepCycle();
    checkWord("pcF", 32'd4, pcF);
    stallF = 1'b1;
    stepCycle();
    checkWord("pcF", 32'd4, pcF);  // Held
    stallF = 1'b0;
    stepCycle();
    checkWord("pcF", 32'd8, pcF);
    pcB    = pcF;
    branch = {8'd0, 24'hFFFFFD};  // Offset of minus three words
    instrF = branch;
    stepCycle();
    setIdle();
    regSrcD = 2'b01;
    immSrcD = immBranch;
    stepCycle();
    setIdle();
    branchTakenE = 1'b1;
    stepCycle();
    setIdle();
    checkWord("pcF", pcB + 32'd8 + extendImm(branch, immBranch), pcF);
  endtask

  // Loads fill R0..R14, each one visible four edges after fetch
  task automatic testLoads();
    for (int i = 0; i < 15; i++) begin
      runInstr(encode(4'd0, regAddr_t'(i), 12'd0), 2'b00, immByte, 1'b1, aluAdd,
               1'b1, 1'b1, $urandom, 1'b0);
    end
  endtask

  task automatic testAlu();
    runInstr(encode(4'd0, 4'd0, 12'($urandom % 256)), 2'b00, immByte, 1'b1, aluAdd,
             1'b0, 1'b1, '0, 1'b1);
    runInstr(encode(4'd1, 4'd1, 12'($urandom % 256)), 2'b00, immByte, 1'b1, aluAdd,
             1'b0, 1'b1, '0, 1'b1);
    runInstr(encode(4'd0, 4'd0, 12'd1), 2'b00, immByte, 1'b0, aluSub, 1'b0, 1'b1, '0, 1'b1);
    runInstr(encode(4'd1, 4'd0, 12'd1), 2'b00, immByte, 1'b0, aluSub, 1'b0, 1'b1, '0, 1'b1);
    runInstr(encode(4'd2, 4'd1, 12'd3), 2'b00, immByte, 1'b0, aluAnd, 1'b0, 1'b1, '0, 1'b1);
    runInstr(encode(4'd4, 4'd0, 12'd5), 2'b00, immByte, 1'b0, aluOrr, 1'b0, 1'b1, '0, 1'b1);
    runInstr(encode(4'd3, 4'd1, 12'hABC), 2'b00, immWord12, 1'b1, aluAdd, 1'b0, 1'b1, '0, 1'b1);
  endtask

  // R0 += immA, then R1 = R0 + immB issued gap cycles later
  task automatic testForward(input int gap);
    word_t       immA;
    word_t       immB;
    word_t       resA;
    forwardSel_t sel;
    immA = $urandom % 256;
    immB = $urandom % 256;
    resA = refRegs[0] + immA;
    sel  = (gap == 1) ? fwdMemory : fwdWriteback;
    for (int c = 0; c <= gap + 5; c++) begin
      setIdle();
      if (c == 0) instrF = encode(4'd0, 4'd0, immA[11:0]);
      if (c == gap) instrF = encode(4'd0, 4'd1, immB[11:0]);
      if (c == gap + 2) begin
        forwardAE = sel;  // Stale R0 read in decode
        forwardBE = sel;  // Store data path too
      end
      if (c == 3) checkWord("aluOutM", resA, aluOutM);
      if (c == gap + 3) begin
        checkWord("aluOutM", resA + immB, aluOutM);
        checkWord("writeDataM", resA, writeDataM);
      end
      if (c == 4 || c == gap + 4) regWriteW = 1'b1;
      stepCycle();
    end
    refRegs[0] = resA;
    refRegs[1] = resA + immB;
    checkWord("r0", refRegs[0], r0);
    checkWord("r1", refRegs[1], r1);
  endtask

  task automatic testHazards();
    regAddr_t pRn;
    regAddr_t pRd;
    regAddr_t pRm;
    regAddr_t qRn;
    regAddr_t qRd;
    regAddr_t qRm;
    for (int i = 0; i < 6; i++) begin
      pRn = regAddr_t'($urandom);
      pRd = regAddr_t'($urandom);
      pRm = regAddr_t'($urandom);
      qRn = (i % 2 == 0) ? pRd : regAddr_t'($urandom);  // Force some hits
      qRd = regAddr_t'($urandom);
      qRm = (i % 3 == 0) ? pRd : regAddr_t'($urandom);
      instrF = {12'd0, pRn, pRd, 8'd0, pRm};
      stepCycle();
      instrF = {12'd0, qRn, qRd, 8'd0, qRm};
      stepCycle();
      // Q stays on the bus, so a copy sits in E while P is in W
      checkWord("match12DE", {31'd0, (qRn == pRd) || (qRm == pRd)}, {31'd0, match12DE});
      stepCycle();
      instrF = nopInstr;
      checkWord("match1EM", {31'd0, qRn == pRd}, {31'd0, match1EM});
      checkWord("match2EM", {31'd0, qRm == pRd}, {31'd0, match2EM});
      stepCycle();
      checkWord("match1EW", {31'd0, qRn == pRd}, {31'd0, match1EW});
      checkWord("match2EW", {31'd0, qRm == pRd}, {31'd0, match2EW});
      stepCycle();
      stepCycle();
    end
    // Store form reads Rd as the second operand
    runInstr(encode(4'd2, 4'd6, 12'd9), 2'b10, immByte, 1'b1, aluAdd, 1'b0, 1'b0, '0, 1'b1);
  endtask

  task automatic testFlush();
    instrF = encode(4'd3, 4'd2, 12'h07F);
    flushD = 1'b1;  // Slot becomes a NOP
    stepCycle();
    setIdle();
    stepCycle();
    setIdle();
    stepCycle();
    checkWord("aluOutM", refRegs[0], aluOutM);
    checkWord("writeDataM", refRegs[0], writeDataM);
  endtask

  initial begin
    void'($urandom(48));
    cycleCount = 0;
    setIdle();
    rst = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    testFetch();
    testLoads();
    testAlu();
    testForward(1);
    testForward(2);
    testHazards();
    testFlush();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* armDatapath.f */
source/armPkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/registerFile.sv
source/executeStage.sv
source/memWritebackStage.sv
source/hazardMatch.sv
source/armDatapath.sv
tests/armDatapathTb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= armDatapathTb
FILELIST  ?= armDatapath.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
